// ==== design/fpu_lite.sv ====
//--------------------------------------------------------------------------
// Reduced FP offload subsystem, sign injection and FMV only
// Issue and result follow valid/ready, one instruction per transfer
// Latency is two cycles from issue to result with ready held high
// Only lane 0 takes the integer operand
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpu_lite_macros.svh"

module fpu_lite (
  input  logic               clk_i,
  input  logic               reset_i,
  // Issue side
  input  logic               issue_valid_i,
  output logic               issue_ready_o,
  input  logic [31:0]        issue_instr_i,
  input  logic [`XLEN-1:0]   issue_int_op_i,
  output logic               issue_accept_o,
  // Result side
  output logic               result_valid_o,
  input  logic               result_ready_i,
  output logic [`FLEN-1:0]   result_data_o,
  output logic [`FPR_AW-1:0] result_rd_o,
  output logic               result_we_o
);

  logic [`NUM_LANES-1:0][`FPR_AW-1:0] rs_addr;
  logic [`NUM_LANES-1:0][`FLEN-1:0]   rf_rdata;
  logic [`NUM_LANES-1:0][`FLEN-1:0]   operand;
  logic                               use_int;
  logic                               rf_we;
  logic [`FPR_AW-1:0]                 rf_waddr;
  logic [`FLEN-1:0]                   rf_wdata;

  exec_if ex_bus ();
  fwd_if  fwd_bus ();

  assign issue_ready_o = ex_bus.advance;

  fpu_lite_issue_stage i_issue_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .issue_valid_i  (issue_valid_i),
    .issue_instr_i  (issue_instr_i),
    .issue_accept_o (issue_accept_o),
    .rs_addr_o      (rs_addr),
    .use_int_o      (use_int),
    .ex             (ex_bus)
  );

  fpu_lite_regfile i_regfile (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .raddr_i (rs_addr),
    .rdata_o (rf_rdata),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata)
  );

  for (genvar l = 0; l < `NUM_LANES; l++) begin : gen_lane
    fpu_lite_operand_lane i_lane (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .rs_addr_i  (rs_addr[l]),
      .rf_rdata_i (rf_rdata[l]),
      .int_op_i   (issue_int_op_i),
      .use_int_i  ((l == 0) ? use_int : 1'b0),
      .fwd        (fwd_bus),
      .ex         (ex_bus),
      .operand_o  (operand[l])
    );
  end

  fpu_lite_sign_unit i_sign_unit (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .operand_i      (operand),
    .ex             (ex_bus),
    .fwd            (fwd_bus),
    .result_ready_i (result_ready_i),
    .result_valid_o (result_valid_o),
    .result_data_o  (result_data_o),
    .result_rd_o    (result_rd_o),
    .result_we_o    (result_we_o),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata)
  );

endmodule

// ==== design/fpu_lite_if.sv ====
//--------------------------------------------------------------------------
// Internal buses between issue stage, operand lanes and sign unit
// Forwarding valids already mean "holds a floating-point destination"
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpu_lite_macros.svh"

interface exec_if;
  import fpu_lite_pipe_pkg::*;

  logic               ex_valid;
  exec_op_e           ex_op;
  logic [`FPR_AW-1:0] ex_rd;
  logic               ex_rd_is_fp;
  // Pipeline enable, low only while the result stage is stalled
  logic               advance;

  modport issue (output ex_valid, ex_op, ex_rd, ex_rd_is_fp, input advance);
  modport exec  (input ex_valid, ex_op, ex_rd, ex_rd_is_fp, output advance);
  modport lane  (input advance);
endinterface

interface fwd_if;
  logic               ex_fwd_valid;
  logic [`FPR_AW-1:0] ex_fwd_rd;
  logic [`FLEN-1:0]   ex_fwd_data;
  logic               wb_fwd_valid;
  logic [`FPR_AW-1:0] wb_fwd_rd;
  logic [`FLEN-1:0]   wb_fwd_data;

  modport source (output ex_fwd_valid, ex_fwd_rd, ex_fwd_data,
                  output wb_fwd_valid, wb_fwd_rd, wb_fwd_data);
  modport lane   (input ex_fwd_valid, ex_fwd_rd, ex_fwd_data,
                  input wb_fwd_valid, wb_fwd_rd, wb_fwd_data);
endinterface

// ==== design/fpu_lite_isa_pkg.sv ====
//--------------------------------------------------------------------------
// Instruction word views used by the issue stage
// The r4 view is read only for its fmt field, which shares the funct7 bits
//--------------------------------------------------------------------------
`include "fpu_lite_macros.svh"

package fpu_lite_isa_pkg;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [`FPR_AW-1:0] rs2;
    logic [`FPR_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`FPR_AW-1:0] rd;
    logic [6:0]         opcode;
  } instr_r_t;

  // Fused layout, rs3 and fmt sit where funct7 is
  typedef struct packed {
    logic [`FPR_AW-1:0] rs3;
    logic [1:0]         fmt;
    logic [`FPR_AW-1:0] rs2;
    logic [`FPR_AW-1:0] rs1;
    logic [2:0]         rm;
    logic [`FPR_AW-1:0] rd;
    logic [6:0]         opcode;
  } instr_r4_t;

  typedef union packed {
    instr_r_t  r;
    instr_r4_t r4;
  } instr_u;

endpackage

// ==== design/fpu_lite_issue_stage.sv ====
//--------------------------------------------------------------------------
// Decode and accept for the supported OP-FP subset, execute-stage metadata
// Accept is combinational and only meaningful while issue_valid_i is high
// Rejected transfers are consumed and leave the execute stage empty
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpu_lite_macros.svh"

module fpu_lite_issue_stage (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      issue_valid_i,
  input  fpu_lite_isa_pkg::instr_u                  issue_instr_i,
  output logic                                      issue_accept_o,
  output logic [`NUM_LANES-1:0][`FPR_AW-1:0]        rs_addr_o,
  output logic                                      use_int_o,
  exec_if.issue                                     ex
);
  import fpu_lite_pipe_pkg::*;

  logic     dec_ok;
  exec_op_e dec_op;
  logic     dec_rd_is_fp;

  // Source addresses straight from the r-type fields
  assign rs_addr_o[0] = issue_instr_i.r.rs1;
  assign rs_addr_o[1] = issue_instr_i.r.rs2;

  always_comb begin
    dec_ok       = 1'b0;
    dec_op       = SGNJ;
    dec_rd_is_fp = 1'b1;
    use_int_o    = 1'b0;
    // fmt lives in funct7[1:0], so the group compare ignores it
    if (issue_instr_i.r.opcode == `OPC_OP_FP && issue_instr_i.r4.fmt == `FMT_S) begin
      case ({issue_instr_i.r.funct7[6:2], 2'b00})
        `F7_FSGNJ: begin
          dec_ok = 1'b1;
          case (issue_instr_i.r.funct3)
            3'b000:  dec_op = SGNJ;
            3'b001:  dec_op = SGNJN;
            3'b010:  dec_op = SGNJX;
            default: dec_ok = 1'b0;
          endcase
        end
        `F7_FMV_X_W: begin
          // funct3 001 here would be FCLASS, not supported
          dec_ok       = (issue_instr_i.r.funct3 == 3'b000) && (issue_instr_i.r.rs2 == '0);
          dec_op       = MV_X_W;
          dec_rd_is_fp = 1'b0;
        end
        `F7_FMV_W_X: begin
          dec_ok    = (issue_instr_i.r.funct3 == 3'b000) && (issue_instr_i.r.rs2 == '0);
          dec_op    = MV_W_X;
          use_int_o = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign issue_accept_o = dec_ok;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex.ex_valid    <= 1'b0;
      ex.ex_op       <= SGNJ;
      ex.ex_rd       <= '0;
      ex.ex_rd_is_fp <= 1'b0;
    end else if (ex.advance) begin
      ex.ex_valid    <= issue_valid_i & dec_ok;
      ex.ex_op       <= dec_op;
      ex.ex_rd       <= issue_instr_i.r.rd;
      ex.ex_rd_is_fp <= dec_rd_is_fp;
    end
  end

  a_ex_op_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    ex.ex_valid |-> ex.ex_op inside {SGNJ, SGNJN, SGNJX, MV_X_W, MV_W_X});

endmodule

// ==== design/fpu_lite_macros.svh ====
//--------------------------------------------------------------------------
// Widths, sizes and RISC-V field codes for the reduced FPU
// The funct7 codes carry a zero fmt field, so decode compares bits 6:2 only
// Only the S format exists, no D or H
//--------------------------------------------------------------------------
`ifndef FPU_LITE_MACROS_SVH
`define FPU_LITE_MACROS_SVH

`define FLEN       32
`define XLEN       32
`define NUM_FPR    32
`define FPR_AW     5
`define NUM_LANES  2

// OP-FP major opcode and funct7 groups
`define OPC_OP_FP  7'b1010011
`define F7_FSGNJ   7'b0010000
`define F7_FMV_X_W 7'b1110000
`define F7_FMV_W_X 7'b1111000
`define FMT_S      2'b00

`endif

// ==== design/fpu_lite_operand_lane.sv ====
//--------------------------------------------------------------------------
// One source operand: integer bypass, result forwarding, operand register
// Execute-stage result wins over the result stage, register file is last
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpu_lite_macros.svh"

module fpu_lite_operand_lane (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [`FPR_AW-1:0] rs_addr_i,
  input  logic [`FLEN-1:0]   rf_rdata_i,
  input  logic [`XLEN-1:0]   int_op_i,
  input  logic               use_int_i,
  fwd_if.lane                fwd,
  exec_if.lane               ex,
  output logic [`FLEN-1:0]   operand_o
);

  logic             ex_hit;
  logic             wb_hit;
  logic [`FLEN-1:0] operand_d;

  assign ex_hit = fwd.ex_fwd_valid && (fwd.ex_fwd_rd == rs_addr_i);
  assign wb_hit = fwd.wb_fwd_valid && (fwd.wb_fwd_rd == rs_addr_i);

  always_comb begin
    if (use_int_i) begin
      operand_d = int_op_i;
    end else if (ex_hit) begin
      operand_d = fwd.ex_fwd_data;
    end else if (wb_hit) begin
      operand_d = fwd.wb_fwd_data;
    end else begin
      operand_d = rf_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      operand_o <= '0;
    end else if (ex.advance) begin
      operand_o <= operand_d;
    end
  end

  // Pending writeback must be captured, the register file is still stale
  a_wb_fwd_taken: assert property (@(posedge clk_i) disable iff (reset_i)
    ex.advance && !use_int_i && wb_hit && !ex_hit |=> operand_o == $past(fwd.wb_fwd_data));

endmodule

// ==== design/fpu_lite_pipe_pkg.sv ====
//--------------------------------------------------------------------------
// Operation codes carried through the execute stage
// Encodings above MV_W_X are never produced by the decoder
//--------------------------------------------------------------------------
package fpu_lite_pipe_pkg;

  typedef enum logic [2:0] {
    SGNJ,
    SGNJN,
    SGNJX,
    MV_X_W,
    MV_W_X
  } exec_op_e;

endpackage

// ==== design/fpu_lite_regfile.sv ====
//--------------------------------------------------------------------------
// Single-precision register file, 32 entries, cleared by reset
// Reads are combinational, so a same-cycle write is not visible yet
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpu_lite_macros.svh"

module fpu_lite_regfile (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [`NUM_LANES-1:0][`FPR_AW-1:0]   raddr_i,
  output logic [`NUM_LANES-1:0][`FLEN-1:0]     rdata_o,
  input  logic                                 we_i,
  input  logic [`FPR_AW-1:0]                   waddr_i,
  input  logic [`FLEN-1:0]                     wdata_i
);

  logic [`NUM_FPR-1:0][`FLEN-1:0] regs_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_q <= '0;
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // One read port per operand lane
  for (genvar p = 0; p < `NUM_LANES; p++) begin : gen_rd_port
    assign rdata_o[p] = regs_q[raddr_i[p]];
  end

  a_we_known: assert property (@(posedge clk_i) disable iff (reset_i)
    !$isunknown(we_i));

endmodule

// ==== design/fpu_lite_sign_unit.sv ====
//--------------------------------------------------------------------------
// Sign injection and moves, result stage and writeback control
// A result leaves only through the result handshake, FP destinations are
// written to the register file at that same edge
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpu_lite_macros.svh"

module fpu_lite_sign_unit (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [`NUM_LANES-1:0][`FLEN-1:0]    operand_i,
  exec_if.exec                                ex,
  fwd_if.source                               fwd,
  input  logic                                result_ready_i,
  output logic                                result_valid_o,
  output logic [`FLEN-1:0]                    result_data_o,
  output logic [`FPR_AW-1:0]                  result_rd_o,
  output logic                                result_we_o,
  output logic                                rf_we_o,
  output logic [`FPR_AW-1:0]                  rf_waddr_o,
  output logic [`FLEN-1:0]                    rf_wdata_o
);
  import fpu_lite_pipe_pkg::*;

  logic               advance;
  logic [`FLEN-1:0]   ex_result;
  logic               res_valid_q;
  logic [`FLEN-1:0]   res_data_q;
  logic [`FPR_AW-1:0] res_rd_q;
  logic               res_rd_is_fp_q;

  // ------------------------------------------------------------------------
  // Execute
  // ------------------------------------------------------------------------
  always_comb begin
    ex_result = operand_i[0];
    case (ex.ex_op)
      SGNJ:    ex_result[`FLEN-1] = operand_i[1][`FLEN-1];
      SGNJN:   ex_result[`FLEN-1] = ~operand_i[1][`FLEN-1];
      SGNJX:   ex_result[`FLEN-1] = operand_i[0][`FLEN-1] ^ operand_i[1][`FLEN-1];
      default: ;
    endcase
  end

  // Stall only when a held result is not taken
  assign advance    = ~res_valid_q | result_ready_i;
  assign ex.advance = advance;

  // ------------------------------------------------------------------------
  // Result stage
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      res_valid_q    <= 1'b0;
      res_data_q     <= '0;
      res_rd_q       <= '0;
      res_rd_is_fp_q <= 1'b0;
    end else if (advance) begin
      res_valid_q    <= ex.ex_valid;
      res_data_q     <= ex_result;
      res_rd_q       <= ex.ex_rd;
      res_rd_is_fp_q <= ex.ex_rd_is_fp;
    end
  end

  assign result_valid_o = res_valid_q;
  assign result_data_o  = res_data_q;
  assign result_rd_o    = res_rd_q;
  // Integer destination only for FMV.X.W
  assign result_we_o    = res_valid_q & ~res_rd_is_fp_q;

  assign rf_we_o    = res_valid_q & res_rd_is_fp_q & result_ready_i;
  assign rf_waddr_o = res_rd_q;
  assign rf_wdata_o = res_data_q;

  // Forwarding sources, younger one from execute
  assign fwd.ex_fwd_valid = ex.ex_valid & ex.ex_rd_is_fp;
  assign fwd.ex_fwd_rd    = ex.ex_rd;
  assign fwd.ex_fwd_data  = ex_result;
  assign fwd.wb_fwd_valid = res_valid_q & res_rd_is_fp_q;
  assign fwd.wb_fwd_rd    = res_rd_q;
  assign fwd.wb_fwd_data  = res_data_q;

  a_result_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_data_o)
      && $stable(result_rd_o) && $stable(result_we_o));

endmodule

// ==== fpu_lite.f ====
+incdir+design
design/fpu_lite_pipe_pkg.sv
design/fpu_lite_isa_pkg.sv
design/fpu_lite_if.sv
design/fpu_lite_issue_stage.sv
design/fpu_lite_operand_lane.sv
design/fpu_lite_regfile.sv
design/fpu_lite_sign_unit.sv
design/fpu_lite.sv
verification/fpu_lite_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the fpu_lite testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fpu_lite_tb \
  -f fpu_lite.f -o sim_fpu_lite

./obj_dir/sim_fpu_lite | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "Simulation finished without errors"
else
  echo "Simulation reported a failure, see sim.log" >&2
  exit 1
fi

// ==== verification/fpu_lite_patterns.txt ====
// test instr int_op accept exp_data exp_rd exp_we, all hex except test
// test 5 runs with random result_ready_i, rejected lines expect no result
2 F00000D3 3FC00000 1 3FC00000 01 0
2 E0008553 DEADBEEF 1 3FC00000 0A 1
2 F0000153 C0490FDB 1 C0490FDB 02 0
2 E00105D3 00000000 1 C0490FDB 0B 1
3 F00001D3 40490FDB 1 40490FDB 03 0
3 F0000253 BF800000 1 BF800000 04 0
3 204182D3 00000000 1 C0490FDB 05 0
3 20419353 00000000 1 40490FDB 06 0
3 204223D3 00000000 1 3F800000 07 0
3 20412453 00000000 1 40490FDB 08 0
4 F00004D3 12345678 1 12345678 09 0
4 20949553 00000000 1 92345678 0A 0
4 209525D3 00000000 1 92345678 0B 0
4 204584D3 00000000 1 92345678 09 0
4 E0048653 00000000 1 92345678 0C 1
4 F00006D3 00000001 1 00000001 0D 0
4 F00006D3 80000002 1 80000002 0D 0
4 20D68753 00000000 1 80000002 0E 0
5 F00007D3 7F800000 1 7F800000 0F 0
5 20F79853 00000000 1 FF800000 10 0
5 E00806D3 00000000 1 FF800000 0D 1
5 204828D3 00000000 1 7F800000 11 0
5 21118953 00000000 1 40490FDB 12 0
5 E0090753 00000000 1 40490FDB 0E 1
5 F00009D3 A5A5A5A5 1 A5A5A5A5 13 0
5 E00987D3 00000000 1 A5A5A5A5 0F 1
6 22418A53 00000000 0 00000000 00 0
6 00418A53 00000000 0 00000000 00 0
6 20321A53 00000000 1 BF800000 14 0
6 00000013 00000000 0 00000000 00 0
6 2041BA53 00000000 0 00000000 00 0
6 E00A0853 00000000 1 BF800000 10 1

// ==== verification/fpu_lite_tb.sv ====
//--------------------------------------------------------------------------
// Testbench for the reduced FPU, stimulus and expectations from the
// pattern file, read relative to the project root
// Test 5 toggles result_ready_i from an LCG, every other test keeps it high
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpu_lite_macros.svh"

module fpu_lite_tb;

  localparam int MAX_PAT = 64;
  localparam int TIMEOUT = 200;

  logic               clk_i = 1'b0;
  logic               reset_i;
  logic               issue_valid_i;
  logic               issue_ready_o;
  logic [31:0]        issue_instr_i;
  logic [`XLEN-1:0]   issue_int_op_i;
  logic               issue_accept_o;
  logic               result_valid_o;
  logic               result_ready_i;
  logic [`FLEN-1:0]   result_data_o;
  logic [`FPR_AW-1:0] result_rd_o;
  logic               result_we_o;

  // Pattern table, one entry per file line
  int          pat_count;
  int          pat_test [MAX_PAT];
  logic [31:0] pat_instr [MAX_PAT];
  logic [31:0] pat_int [MAX_PAT];
  logic [31:0] pat_acc [MAX_PAT];
  logic [31:0] pat_data [MAX_PAT];
  logic [31:0] pat_rd [MAX_PAT];
  logic [31:0] pat_we [MAX_PAT];

  // Expected results in issue order
  logic [31:0] exp_data_q [$];
  logic [31:0] exp_rd_q [$];
  logic [31:0] exp_we_q [$];
  int          exp_cyc_q [$];

  int          cycle_cnt;
  int          check_count;
  int          error_count;
  bit          timed_out;
  bit          monitor_on;
  bit          random_ready;
  logic [31:0] lcg_state;

  fpu_lite i_fpu_lite (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  function automatic logic next_ready_bit();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[16];
  endfunction

  always @(posedge clk_i) begin
    if (random_ready) begin
      #1 result_ready_i = next_ready_bit();
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
               $time, name, exp, act);
      error_count++;
    end
  endtask

  // ------------------------------------------------------------------------
  // Result side, sampled mid-cycle where every output is settled
  // ------------------------------------------------------------------------
  always @(negedge clk_i) begin : result_monitor
    int issue_cyc;
    if (monitor_on) begin
      if (result_valid_o && !result_ready_i) begin
        check_value("issue_ready_o", 32'd0, 32'(issue_ready_o));
      end
      if (result_valid_o && result_ready_i) begin
        assert (exp_data_q.size() != 0) else begin
          $display("Result handshake at %0t with no instruction pending", $time);
          error_count++;
        end
        if (exp_data_q.size() != 0) begin
          check_value("result_data_o", exp_data_q.pop_front(), 32'(result_data_o));
          check_value("result_rd_o", exp_rd_q.pop_front(), 32'(result_rd_o));
          check_value("result_we_o", exp_we_q.pop_front(), 32'(result_we_o));
          issue_cyc = exp_cyc_q.pop_front();
          if (!random_ready) begin
            check_value("result latency", 32'd2, 32'(cycle_cnt - issue_cyc));
          end
        end
      end
    end
  end

  task automatic load_patterns();
    int    fd;
    int    n;
    int    t;
    string line;
    logic [31:0] ins, iop, acc, dat, rd, we;
    fd = $fopen("verification/fpu_lite_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file");
      error_count++;
      return;
    end
    while (!$feof(fd) && pat_count < MAX_PAT) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line[0] == "/") continue;
      n = $sscanf(line, "%d %h %h %h %h %h %h", t, ins, iop, acc, dat, rd, we);
      if (n == 7) begin
        pat_test[pat_count]  = t;
        pat_instr[pat_count] = ins;
        pat_int[pat_count]   = iop;
        pat_acc[pat_count]   = acc;
        pat_data[pat_count]  = dat;
        pat_rd[pat_count]    = rd;
        pat_we[pat_count]    = we;
        pat_count++;
      end else begin
        $display("Malformed pattern line: %s", line);
        error_count++;
      end
    end
    $fclose(fd);
  endtask

  // Drives one instruction and holds it until the issue handshake
  task automatic issue_one(input int idx);
    int waited;
    waited = 0;
    if (timed_out) return;
    issue_valid_i  = 1'b1;
    issue_instr_i  = pat_instr[idx];
    issue_int_op_i = pat_int[idx];
    @(negedge clk_i);
    while (!issue_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!issue_ready_o) begin
      $display("Timeout: issue_ready_o stayed low for %0d cycles", TIMEOUT);
      timed_out = 1'b1;
      error_count++;
    end else begin
      check_value("issue_accept_o", pat_acc[idx], 32'(issue_accept_o));
      if (pat_acc[idx] != 0) begin
        exp_data_q.push_back(pat_data[idx]);
        exp_rd_q.push_back(pat_rd[idx]);
        exp_we_q.push_back(pat_we[idx]);
        exp_cyc_q.push_back(cycle_cnt);
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      $display("Timeout: %0d results never arrived", exp_data_q.size());
      timed_out = 1'b1;
      error_count++;
    end
    // Short quiet window to catch results nobody asked for
    repeat (3) @(posedge clk_i);
    #1;
  endtask

  task automatic run_test(input int id, input string name);
    int errs_before;
    errs_before = error_count;
    if (timed_out) return;
    random_ready = (id == 5);
    for (int i = 0; i < pat_count; i++) begin
      if (pat_test[i] == id) issue_one(i);
    end
    issue_valid_i = 1'b0;
    wait_results();
    random_ready = 1'b0;
    @(posedge clk_i);
    #1;
    result_ready_i = 1'b1;
    $display("test %0d (%s) done, %0d errors", id, name, error_count - errs_before);
  endtask

  initial begin
    reset_i        = 1'b1;
    issue_valid_i  = 1'b0;
    issue_instr_i  = '0;
    issue_int_op_i = '0;
    result_ready_i = 1'b1;
    lcg_state      = 32'd68;
    load_patterns();
    if (pat_count == 0) begin
      $display("No patterns were loaded");
      error_count++;
    end
    repeat (8) @(posedge clk_i);
    #1;
    reset_i    = 1'b0;
    monitor_on = 1'b1;
    @(negedge clk_i);
    check_value("result_valid_o", 32'd0, 32'(result_valid_o));
    check_value("issue_ready_o", 32'd1, 32'(issue_ready_o));
    @(posedge clk_i);
    #1;
    $display("test 1 (reset state) done, %0d errors", error_count);
    run_test(2, "moves");
    run_test(3, "sign injection");
    run_test(4, "dependent chains");
    run_test(5, "back-pressure");
    run_test(6, "rejected instructions");
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
